// ==== files.f ====
+incdir+verilog
+incdir+testbench
verilog/ahb_om_pkg.sv
verilog/ahb_om_arbiter.sv
verilog/ahb_om_addr_stage.sv
verilog/ahb_om_data_stage.sv
verilog/ahb_om_output_stage.sv
testbench/tb_ahb_om.sv

// ==== testbench/tb_ahb_om_tasks.svh ====
// Directed tests for the AHB output stage
// Cycle helpers, typed compare tasks, test tasks and the count report

// ----------------------------------------
// Cycle helpers
// ----------------------------------------
task automatic tick();
  @(posedge HCLK);
  #1;                                  // Drive point after the edge
endtask

task automatic settle();
  #1;                                  // Sample point, outputs stable
endtask

// Call at a sample point, returns at the drive point after a completing edge
task automatic wait_transfer();
  int n;
  begin
    n = 0;
    while (o_hreadymux !== 1'b1 && n < ready_timeout)
    begin
      tick();
      settle();
      n++;
    end
    if (o_hreadymux !== 1'b1)
    begin
      $display("Timeout at %0t ns: o_hreadymux never went high", $time);
      timeouts++;
    end
    tick();
  end
endtask

// ----------------------------------------
// Address-phase control words
// ----------------------------------------
// HSEL, HTRANS, HWRITE, HSIZE, HBURST, HMASTER, HMASTLOCK in one word
function automatic ahb_om_pkg::addr_t ctrl_out();
  ctrl_out = {17'd0, o_hsel, o_htrans, o_hwrite, o_hsize, o_hburst, o_hmaster, o_hmastlock};
endfunction

// Port n holding a selected NONSEQ word write
function automatic ahb_om_pkg::addr_t ctrl_word(input int n, input logic lock);
  ahb_om_pkg::master_t id;
  begin
    id        = n[3:0];                // Master ID equals port number
    ctrl_word = {17'd0, 1'b1, 2'b10, 1'b1, 3'b010, 3'b000, id, lock};
  end
endfunction

// ----------------------------------------
// Compare tasks
// ----------------------------------------
task automatic check_addr(input ahb_om_pkg::addr_t got, input ahb_om_pkg::addr_t exp,
                          input string what);
  checks++;
  if (got !== exp)
  begin
    $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    mismatches++;
  end
endtask

task automatic check_data(input ahb_om_pkg::data_t got, input ahb_om_pkg::data_t exp,
                          input string what);
  checks++;
  if (got !== exp)
  begin
    $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    mismatches++;
  end
endtask

task automatic check_active(input ahb_om_pkg::port_vec_t got,
                            input ahb_om_pkg::port_vec_t exp, input string what);
  checks++;
  if (got !== exp)
  begin
    $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    mismatches++;
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  checks++;
  if (got !== exp)
  begin
    $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    mismatches++;
  end
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic reset_values();
  reset_dut();
  settle();
  check_flag(o_hreadymux, 1'b1, "o_hreadymux after reset");
  check_active(active, '0, "active after reset");
  check_flag(o_hsel, 1'b0, "o_hsel after reset");
  check_addr(o_haddr, '0, "o_haddr after reset");
  check_addr(ctrl_out(), '0, "control after reset");
endtask

task automatic single_port_write();
  reset_dut();
  set_port(1, 1'b1, 1'b0);             // NONSEQ write on port 1
  settle();
  wait_transfer();                     // Request sampled, grant next cycle
  settle();
  check_active(active, 3'b010, "active for port 1");
  check_addr(o_haddr, addr_p1, "o_haddr for port 1");
  wait_transfer();                     // Address phase completes
  set_port(1, 1'b0, 1'b0);
  settle();
  check_data(o_hwdata, wdata_p1, "o_hwdata for port 1");
endtask

task automatic round_robin_rotation();
  int exp_port;
  begin
    reset_dut();
    for (int k = 0; k < 3; k++)
      set_port(k, 1'b1, 1'b0);
    settle();
    for (int i = 0; i < 4; i++)
    begin
      exp_port = i % 3;                // Search begins after port 2
      wait_transfer();
      settle();
      check_active(active, ahb_om_pkg::port_vec_t'(1 << exp_port), "active in rotation");
      check_addr(o_haddr, addr_of(exp_port), "o_haddr in rotation");
      check_addr(ctrl_out(), ctrl_word(exp_port, 1'b0), "control in rotation");
      if (i > 0)
        check_data(o_hwdata, wdata_of((i - 1) % 3), "o_hwdata in rotation");
    end
  end
endtask

task automatic back_pressure_hold();
  reset_dut();
  for (int k = 0; k < 3; k++)
    set_port(k, 1'b1, 1'b0);
  settle();
  wait_transfer();                     // Port 0 address phase
  settle();
  wait_transfer();                     // Port 1 address, port 0 data
  i_hreadyout = 1'b0;                  // Slave inserts wait states
  repeat (3)
  begin
    settle();
    check_flag(o_hreadymux, 1'b0, "o_hreadymux under wait state");
    check_active(active, 3'b010, "active under wait state");
    check_addr(o_haddr, addr_p1, "o_haddr under wait state");
    check_data(o_hwdata, wdata_p0, "o_hwdata under wait state");
    tick();
  end
  i_hreadyout = 1'b1;
  settle();
  wait_transfer();
  settle();
  check_active(active, 3'b100, "active after release");
  check_addr(o_haddr, addr_p2, "o_haddr after release");
  check_data(o_hwdata, wdata_p1, "o_hwdata after release");
endtask

task automatic locked_sequence_hold();
  reset_dut();
  set_port(0, 1'b1, 1'b1);             // Locked NONSEQ on port 0
  set_port(1, 1'b1, 1'b0);
  set_port(2, 1'b1, 1'b0);
  settle();
  wait_transfer();
  settle();
  check_active(active, 3'b001, "active at lock start");
  check_addr(ctrl_out(), ctrl_word(0, 1'b1), "control at lock start");
  wait_transfer();                     // Lock tracker now held
  set_port(0, 1'b0, 1'b1);             // Deselect, lock still high
  settle();
  check_active(active, 3'b001, "active with lock held");
  wait_transfer();
  set_port(0, 1'b1, 1'b1);
  settle();
  check_active(active, 3'b001, "active after deselected cycle");
  wait_transfer();
  set_port(0, 1'b0, 1'b0);             // Sequence over
  settle();
  wait_transfer();
  settle();
  check_active(active, 3'b010, "active after unlock");
  check_addr(o_haddr, addr_p1, "o_haddr after unlock");
  check_addr(ctrl_out(), ctrl_word(1, 1'b0), "control after unlock");
endtask

task automatic idle_return();
  reset_dut();
  for (int k = 0; k < 3; k++)
    set_port(k, 1'b1, 1'b0);
  settle();
  wait_transfer();                     // Port 0 address phase
  settle();
  wait_transfer();                     // Port 0 data phase begins
  for (int k = 0; k < 3; k++)
    set_port(k, 1'b0, 1'b0);           // All requests stop
  i_hreadyout = 1'b0;                  // Last data phase stretched
  settle();
  check_flag(o_hreadymux, 1'b0, "o_hreadymux in last data phase");
  tick();
  i_hreadyout = 1'b1;
  settle();
  wait_transfer();
  settle();
  check_active(active, '0, "active when idle");
  check_addr(o_haddr, '0, "o_haddr when idle");
  check_flag(o_hsel, 1'b0, "o_hsel when idle");
  check_addr(ctrl_out(), '0, "control when idle");
  check_flag(o_hreadymux, 1'b1, "o_hreadymux when idle");
endtask

task automatic report_counts();
  $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
endtask

// ==== testbench/tb_ahb_om.sv ====
// Testbench top for the AHB output stage
// Clock, reset, DUT instance, port drivers and the test sequence

`timescale 1ns/1ps

module tb_ahb_om;

  localparam int ready_timeout = 20;                    // Cycles per wait
  localparam ahb_om_pkg::addr_t addr_p0  = 32'h4000_0010;  // Per-port address table
  localparam ahb_om_pkg::addr_t addr_p1  = 32'h4000_0124;
  localparam ahb_om_pkg::addr_t addr_p2  = 32'h4000_0238;
  localparam ahb_om_pkg::data_t wdata_p0 = 32'hd0a0_1111;  // Per-port write data
  localparam ahb_om_pkg::data_t wdata_p1 = 32'hd1b1_2222;
  localparam ahb_om_pkg::data_t wdata_p2 = 32'hd2c2_3333;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  i_hreadyout;                    // Slave model
  ahb_om_pkg::port_vec_t port_sel;                       // Per-port HSEL
  ahb_om_pkg::port_vec_t port_held;                      // Per-port pending transfer
  ahb_om_pkg::port_vec_t port_lock;                      // Per-port HMASTLOCK
  logic                  o_hsel, o_hwrite, o_hmastlock, o_hreadymux;
  logic                  active_p0, active_p1, active_p2;
  ahb_om_pkg::addr_t     o_haddr;
  ahb_om_pkg::trans_t    o_htrans;
  ahb_om_pkg::size_t     o_hsize;
  ahb_om_pkg::burst_t    o_hburst;
  ahb_om_pkg::master_t   o_hmaster;
  ahb_om_pkg::data_t     o_hwdata;
  ahb_om_pkg::port_vec_t active;
  int                    checks, mismatches, timeouts;

  assign active = {active_p2, active_p1, active_p0};

  `include "tb_ahb_om_tasks.svh"

  // ----------------------------------------
  // Clock and DUT
  // ----------------------------------------
  always #4 HCLK = ~HCLK;                                // 8 ns period

  // HTRANS is NONSEQ while a port holds a transfer, IDLE otherwise
  ahb_om_output_stage UUT (
    .HCLK, .HRESETn, .i_hreadyout,
    .i_sel_p0 (port_sel[0]), .i_held_tran_p0 (port_held[0]), .i_addr_p0 (addr_p0),
    .i_trans_p0 ({port_held[0], 1'b0}), .i_write_p0 (1'b1), .i_size_p0 (3'b010),
    .i_burst_p0 (3'b000), .i_master_p0 (4'd0), .i_mastlock_p0 (port_lock[0]),
    .i_wdata_p0 (wdata_p0),
    .i_sel_p1 (port_sel[1]), .i_held_tran_p1 (port_held[1]), .i_addr_p1 (addr_p1),
    .i_trans_p1 ({port_held[1], 1'b0}), .i_write_p1 (1'b1), .i_size_p1 (3'b010),
    .i_burst_p1 (3'b000), .i_master_p1 (4'd1), .i_mastlock_p1 (port_lock[1]),
    .i_wdata_p1 (wdata_p1),
    .i_sel_p2 (port_sel[2]), .i_held_tran_p2 (port_held[2]), .i_addr_p2 (addr_p2),
    .i_trans_p2 ({port_held[2], 1'b0}), .i_write_p2 (1'b1), .i_size_p2 (3'b010),
    .i_burst_p2 (3'b000), .i_master_p2 (4'd2), .i_mastlock_p2 (port_lock[2]),
    .i_wdata_p2 (wdata_p2),
    .o_hsel, .o_haddr, .o_htrans, .o_hwrite, .o_hsize, .o_hburst, .o_hmaster,
    .o_hmastlock, .o_hwdata, .o_hreadymux, .o_active_p0 (active_p0),
    .o_active_p1 (active_p1), .o_active_p2 (active_p2)
  );

  // ----------------------------------------
  // Port drivers
  // ----------------------------------------
  task automatic set_port(input int n, input logic req, input logic lock);
    port_sel[n]  = req;
    port_held[n] = req;                                  // Request needs both
    port_lock[n] = lock;
  endtask

  // Reset held for 8 rising edges, ports idle
  task automatic reset_dut();
    tick();
    HRESETn     = 1'b0;
    i_hreadyout = 1'b1;
    port_sel    = '0;
    port_held   = '0;
    port_lock   = '0;
    repeat (8) tick();
    HRESETn = 1'b1;
  endtask

  function automatic ahb_om_pkg::addr_t addr_of(input int n);
    addr_of = (n == 0) ? addr_p0 : (n == 1) ? addr_p1 : addr_p2;
  endfunction

  function automatic ahb_om_pkg::data_t wdata_of(input int n);
    wdata_of = (n == 0) ? wdata_p0 : (n == 1) ? wdata_p1 : wdata_p2;
  endfunction

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    i_hreadyout = 1'b1;
    port_sel    = '0;
    port_held   = '0;
    port_lock   = '0;
    checks      = 0;
    mismatches  = 0;
    timeouts    = 0;
    reset_values();
    single_port_write();
    round_robin_rotation();
    back_pressure_hold();
    locked_sequence_hold();
    idle_return();
    report_counts();
    if (mismatches == 0 && timeouts == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verilog/ahb_om_addr_stage.sv ====
// Address phase path of the AHB output stage
// Address/control multiplexer and locked-sequence tracker

`timescale 1ns/1ps

`include "ahb_om_consts.svh"

module ahb_om_addr_stage (
  input  logic                 HCLK,          // AHB clock
  input  logic                 HRESETn,       // Sync reset, active low
  input  ahb_om_pkg::port_id_t i_grant,       // Granted port
  input  logic                 i_no_port,     // Nobody granted
  input  logic                 i_hreadymux,   // Transfer completes
  input  logic                 i_sel_p0,      // Port 0 control
  input  ahb_om_pkg::addr_t    i_addr_p0,
  input  ahb_om_pkg::trans_t   i_trans_p0,
  input  logic                 i_write_p0,
  input  ahb_om_pkg::size_t    i_size_p0,
  input  ahb_om_pkg::burst_t   i_burst_p0,
  input  ahb_om_pkg::master_t  i_master_p0,
  input  logic                 i_mastlock_p0,
  input  logic                 i_sel_p1,      // Port 1 control
  input  ahb_om_pkg::addr_t    i_addr_p1,
  input  ahb_om_pkg::trans_t   i_trans_p1,
  input  logic                 i_write_p1,
  input  ahb_om_pkg::size_t    i_size_p1,
  input  ahb_om_pkg::burst_t   i_burst_p1,
  input  ahb_om_pkg::master_t  i_master_p1,
  input  logic                 i_mastlock_p1,
  input  logic                 i_sel_p2,      // Port 2 control
  input  ahb_om_pkg::addr_t    i_addr_p2,
  input  ahb_om_pkg::trans_t   i_trans_p2,
  input  logic                 i_write_p2,
  input  ahb_om_pkg::size_t    i_size_p2,
  input  ahb_om_pkg::burst_t   i_burst_p2,
  input  ahb_om_pkg::master_t  i_master_p2,
  input  logic                 i_mastlock_p2,
  output logic                 o_hsel,        // Slave select
  output ahb_om_pkg::addr_t    o_haddr,       // Slave address
  output ahb_om_pkg::trans_t   o_htrans,      // Transfer type
  output logic                 o_hwrite,      // Direction
  output ahb_om_pkg::size_t    o_hsize,       // Transfer size
  output ahb_om_pkg::burst_t   o_hburst,      // Burst type, passed through
  output ahb_om_pkg::master_t  o_hmaster,     // Master ID
  output logic                 o_hmastlock,   // Locked transfer
  output logic                 o_lock_arb     // Lock seen by the arbiter
);

  ahb_om_pkg::lock_state_e lock_q;     // Tracker state
  ahb_om_pkg::lock_state_e lock_next;  // Next tracker state
  logic                    trans_busy; // NONSEQ or SEQ on the bus

  // ----------------------------------------
  // Address/control multiplexer
  // ----------------------------------------
  always_comb
  begin
    {o_hsel, o_haddr, o_htrans, o_hwrite} = '0;  // Zeros when idle
    {o_hsize, o_hburst, o_hmaster, o_hmastlock} = '0;
    if (!i_no_port)
    begin
      case (i_grant)
        2'd0 :
        begin
          {o_hsel, o_haddr, o_htrans, o_hwrite} = {i_sel_p0, i_addr_p0, i_trans_p0, i_write_p0};
          {o_hsize, o_hburst, o_hmaster, o_hmastlock} =
            {i_size_p0, i_burst_p0, i_master_p0, i_mastlock_p0};
        end
        2'd1 :
        begin
          {o_hsel, o_haddr, o_htrans, o_hwrite} = {i_sel_p1, i_addr_p1, i_trans_p1, i_write_p1};
          {o_hsize, o_hburst, o_hmaster, o_hmastlock} =
            {i_size_p1, i_burst_p1, i_master_p1, i_mastlock_p1};
        end
        2'd2 :
        begin
          {o_hsel, o_haddr, o_htrans, o_hwrite} = {i_sel_p2, i_addr_p2, i_trans_p2, i_write_p2};
          {o_hsize, o_hburst, o_hmaster, o_hmastlock} =
            {i_size_p2, i_burst_p2, i_master_p2, i_mastlock_p2};
        end
        default : ;                      // Unused index, stay zero
      endcase
    end
  end

  // ----------------------------------------
  // Locked-sequence tracker
  // ----------------------------------------
  // NONSEQ and SEQ both carry bit 1, IDLE and BUSY do not
  assign trans_busy = |(o_htrans & `AHB_TRANS_NONSEQ);

  always_comb
  begin
    lock_next = lock_q;
    if (o_hsel && trans_busy && o_hmastlock)
      lock_next = ahb_om_pkg::LOCK_HELD;     // Locked beat started here
    else if (!o_hmastlock)
      lock_next = ahb_om_pkg::LOCK_IDLE;     // Sequence over
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      lock_q <= ahb_om_pkg::LOCK_IDLE;
    else if (i_hreadymux)
      lock_q <= lock_next;                   // Frozen under wait states
  end

  // Keep the lock even while the master briefly deselects the slave
  assign o_lock_arb = o_hmastlock & ((lock_q == ahb_om_pkg::LOCK_HELD) | o_hsel);

endmodule

// ==== verilog/ahb_om_arbiter.sv ====
// Round-robin arbiter for the AHB output stage
// Request forming, grant and no_port registers, active decode

`timescale 1ns/1ps

`include "ahb_om_consts.svh"

module ahb_om_arbiter (
  input  logic                  HCLK,         // AHB clock
  input  logic                  HRESETn,      // Sync reset, active low
  input  ahb_om_pkg::port_vec_t i_sel,        // Per-port HSEL
  input  ahb_om_pkg::port_vec_t i_held_tran,  // Per-port pending transfer
  input  logic                  i_lock_arb,   // Locked sequence, hold grant
  input  logic                  i_hreadymux,  // Transfer completes
  output ahb_om_pkg::port_id_t  o_grant,      // Address phase port
  output logic                  o_no_port,    // Nobody granted
  output ahb_om_pkg::port_vec_t o_active      // One-hot active per port
);

  // Highest port index, wrap point of the search
  localparam ahb_om_pkg::port_id_t last_port =
    ahb_om_pkg::port_id_t'(`AHB_NUM_PORTS - 1);

  ahb_om_pkg::port_vec_t req;           // Qualified requests
  ahb_om_pkg::port_id_t  grant_q;       // Registered grant
  logic                  no_port_q;     // Registered no-port flag
  ahb_om_pkg::port_id_t  next_grant;    // Search result
  logic                  next_no_port;  // No request found

  // ----------------------------------------
  // Request forming
  // ----------------------------------------
  assign req = i_sel & i_held_tran;     // Selected and holding a transfer

  // ----------------------------------------
  // Round-robin search
  // ----------------------------------------
  // Start after the last granted port and take the first requester
  always_comb
  begin : p_rr_search
    ahb_om_pkg::port_id_t cand;         // Port under test
    next_grant   = grant_q;             // Hold by default
    next_no_port = 1'b1;
    cand         = grant_q;
    for (int k = 0; k < `AHB_NUM_PORTS; k++)
    begin
      cand = (cand == last_port) ? '0 : cand + 1'b1;  // Wrap to port 0
      if (next_no_port && req[cand])
      begin
        next_grant   = cand;            // First hit wins
        next_no_port = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Grant registers
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q   <= last_port;           // First search begins at port 0
      no_port_q <= 1'b1;
    end
    else if (i_hreadymux && !i_lock_arb)
    begin
      grant_q   <= next_grant;          // Unchanged when no request
      no_port_q <= next_no_port;
    end
  end

  // Active decode, only while a port is granted
  always_comb
  begin
    o_active = '0;
    if (!no_port_q)
    begin
      case (grant_q)
        2'd0    : o_active = 3'b001;
        2'd1    : o_active = 3'b010;
        2'd2    : o_active = 3'b100;
        default : o_active = '0;        // Unused index
      endcase
    end
  end

  assign o_grant   = grant_q;
  assign o_no_port = no_port_q;

endmodule

// ==== verilog/ahb_om_consts.svh ====
// Shared constants for the AHB output stage
// Bus widths, input port count and the HTRANS code

`ifndef AHB_OM_CONSTS_SVH
`define AHB_OM_CONSTS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
// HADDR width
`define AHB_ADDR_W 32
// HWDATA width
`define AHB_DATA_W 32

// ----------------------------------------
// Input ports
// ----------------------------------------
// Masters sharing the one slave
`define AHB_NUM_PORTS 3
// Bits needed for a port index
`define AHB_PORT_W 2

// Non-sequential transfer, first beat
`define AHB_TRANS_NONSEQ 2'b10

`endif

// ==== verilog/ahb_om_data_stage.sv ====
// Data phase path of the AHB output stage
// Data port register, HWDATA multiplexer and HREADYMUX generation

`timescale 1ns/1ps

module ahb_om_data_stage (
  input  logic                 HCLK,         // AHB clock
  input  logic                 HRESETn,      // Sync reset, active low
  input  ahb_om_pkg::port_id_t i_grant,      // Address phase port
  input  logic                 i_hsel,       // Slave selected this phase
  input  logic                 i_hreadyout,  // Slave ready
  input  ahb_om_pkg::data_t    i_wdata_p0,   // Port 0 write data
  input  ahb_om_pkg::data_t    i_wdata_p1,   // Port 1 write data
  input  ahb_om_pkg::data_t    i_wdata_p2,   // Port 2 write data
  output ahb_om_pkg::data_t    o_hwdata,     // Slave write data
  output logic                 o_hreadymux   // Transfer done
);

  ahb_om_pkg::port_id_t data_port_q;  // Port owning the data phase
  logic                 slave_sel_q;  // Slave selected in last address phase
  logic                 hreadymux;    // Internal ready

  // ----------------------------------------
  // Data phase registers
  // ----------------------------------------
  // Address phase becomes data phase at each completed transfer
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port_q <= '0;
      slave_sel_q <= 1'b0;              // No data phase pending
    end
    else if (hreadymux)
    begin
      data_port_q <= i_grant;
      slave_sel_q <= i_hsel;
    end
  end

  // ----------------------------------------
  // Write data multiplexer
  // ----------------------------------------
  always_comb
  begin
    case (data_port_q)
      2'd0    : o_hwdata = i_wdata_p0;
      2'd1    : o_hwdata = i_wdata_p1;
      2'd2    : o_hwdata = i_wdata_p2;
      default : o_hwdata = '0;          // Unused index
    endcase
  end

  // Slave ready only counts when it owns the data phase
  assign hreadymux = slave_sel_q ? i_hreadyout : 1'b1;

  assign o_hreadymux = hreadymux;

endmodule

// ==== verilog/ahb_om_output_stage.sv ====
// AHB output stage top level
// Three input ports share one slave through arbiter, address and data stages

`timescale 1ns/1ps

module ahb_om_output_stage (
  input  logic                HCLK,            // AHB clock
  input  logic                HRESETn,         // Sync reset, active low
  input  logic                i_sel_p0,        // Port 0
  input  logic                i_held_tran_p0,
  input  ahb_om_pkg::addr_t   i_addr_p0,
  input  ahb_om_pkg::trans_t  i_trans_p0,
  input  logic                i_write_p0,
  input  ahb_om_pkg::size_t   i_size_p0,
  input  ahb_om_pkg::burst_t  i_burst_p0,
  input  ahb_om_pkg::master_t i_master_p0,
  input  logic                i_mastlock_p0,
  input  ahb_om_pkg::data_t   i_wdata_p0,
  input  logic                i_sel_p1,        // Port 1
  input  logic                i_held_tran_p1,
  input  ahb_om_pkg::addr_t   i_addr_p1,
  input  ahb_om_pkg::trans_t  i_trans_p1,
  input  logic                i_write_p1,
  input  ahb_om_pkg::size_t   i_size_p1,
  input  ahb_om_pkg::burst_t  i_burst_p1,
  input  ahb_om_pkg::master_t i_master_p1,
  input  logic                i_mastlock_p1,
  input  ahb_om_pkg::data_t   i_wdata_p1,
  input  logic                i_sel_p2,        // Port 2
  input  logic                i_held_tran_p2,
  input  ahb_om_pkg::addr_t   i_addr_p2,
  input  ahb_om_pkg::trans_t  i_trans_p2,
  input  logic                i_write_p2,
  input  ahb_om_pkg::size_t   i_size_p2,
  input  ahb_om_pkg::burst_t  i_burst_p2,
  input  ahb_om_pkg::master_t i_master_p2,
  input  logic                i_mastlock_p2,
  input  ahb_om_pkg::data_t   i_wdata_p2,
  input  logic                i_hreadyout,     // Slave ready
  output logic                o_hsel,          // Slave address/control
  output ahb_om_pkg::addr_t   o_haddr,
  output ahb_om_pkg::trans_t  o_htrans,
  output logic                o_hwrite,
  output ahb_om_pkg::size_t   o_hsize,
  output ahb_om_pkg::burst_t  o_hburst,
  output ahb_om_pkg::master_t o_hmaster,
  output logic                o_hmastlock,
  output ahb_om_pkg::data_t   o_hwdata,        // Slave write data
  output logic                o_hreadymux,     // Transfer done
  output logic                o_active_p0,     // Port 0 owns address phase
  output logic                o_active_p1,
  output logic                o_active_p2
);

  ahb_om_pkg::port_id_t  grant;      // Granted port
  logic                  no_port;    // Nobody granted
  logic                  lock_arb;   // Hold grant for locked sequence
  logic                  hreadymux;  // Completed transfer strobe
  ahb_om_pkg::port_vec_t active;     // One-hot active

  // ----------------------------------------
  // Decode: arbitration
  // ----------------------------------------
  ahb_om_arbiter u_arbiter (
    .HCLK, .HRESETn,
    .i_sel       ({i_sel_p2, i_sel_p1, i_sel_p0}),
    .i_held_tran ({i_held_tran_p2, i_held_tran_p1, i_held_tran_p0}),
    .i_lock_arb  (lock_arb),
    .i_hreadymux (hreadymux),
    .o_grant     (grant),
    .o_no_port   (no_port),
    .o_active    (active)
  );

  // ----------------------------------------
  // Execute: address phase
  // ----------------------------------------
  ahb_om_addr_stage u_addr_stage (
    .HCLK, .HRESETn,
    .i_grant (grant), .i_no_port (no_port), .i_hreadymux (hreadymux),
    .i_sel_p0, .i_addr_p0, .i_trans_p0, .i_write_p0,
    .i_size_p0, .i_burst_p0, .i_master_p0, .i_mastlock_p0,
    .i_sel_p1, .i_addr_p1, .i_trans_p1, .i_write_p1,
    .i_size_p1, .i_burst_p1, .i_master_p1, .i_mastlock_p1,
    .i_sel_p2, .i_addr_p2, .i_trans_p2, .i_write_p2,
    .i_size_p2, .i_burst_p2, .i_master_p2, .i_mastlock_p2,
    .o_hsel, .o_haddr, .o_htrans, .o_hwrite,
    .o_hsize, .o_hburst, .o_hmaster, .o_hmastlock,
    .o_lock_arb (lock_arb)
  );

  // Result: data phase and ready
  ahb_om_data_stage u_data_stage (
    .HCLK, .HRESETn,
    .i_grant     (grant),
    .i_hsel      (o_hsel),
    .i_hreadyout,
    .i_wdata_p0, .i_wdata_p1, .i_wdata_p2,
    .o_hwdata,
    .o_hreadymux (hreadymux)
  );

  assign o_hreadymux = hreadymux;
  assign {o_active_p2, o_active_p1, o_active_p0} = active;  // Split per port

endmodule

// ==== verilog/ahb_om_pkg.sv ====
// Types for the AHB output stage
// Vector typedefs for bus fields and the lock tracker states

`include "ahb_om_consts.svh"

package ahb_om_pkg;

  // ----------------------------------------
  // Address and data phase fields
  // ----------------------------------------
  typedef logic [`AHB_ADDR_W-1:0] addr_t;      // HADDR value
  typedef logic [`AHB_DATA_W-1:0] data_t;      // HWDATA value
  typedef logic [1:0]             trans_t;     // HTRANS value
  typedef logic [2:0]             size_t;      // HSIZE value
  typedef logic [2:0]             burst_t;     // HBURST value
  typedef logic [3:0]             master_t;    // HMASTER ID

  // ----------------------------------------
  // Port bookkeeping
  // ----------------------------------------
  typedef logic [`AHB_PORT_W-1:0]    port_id_t;   // Input port index
  typedef logic [`AHB_NUM_PORTS-1:0] port_vec_t;  // One bit per port

  // Locked sequence tracker
  typedef enum logic
  {
    LOCK_IDLE,   // No locked sequence seen
    LOCK_HELD    // Locked sequence in progress
  } lock_state_e;

endpackage
